// File: filelist.f
logic/sw_pkg.sv
logic/pe_link_if.sv
logic/sw_pe.sv
logic/sw_pe_array.sv
logic/score_max_tree.sv
logic/sw_align_ctrl.sv
logic/sw_align_top.sv
testbench/sw_checker.sv
testbench/tb_sw_align.sv

// File: run_sim.sh
#!/bin/sh
# build and run the aligner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f filelist.f \
    --top-module tb_sw_align -o Vtb_sw_align
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_sw_align)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_sw_align.sv
module tb_sw_align;
    import sw_pkg::*;

    localparam int NUM_RANDOM = 200;
    localparam int NUM_TESTS  = NUM_RANDOM + 5;
    localparam int NEG_BIG    = -100000;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_start;
    logic [2*NUM_PE-1:0]   i_ref;
    logic                  i_query_valid;
    base_t                 i_query_base;
    logic                  i_query_last;
    logic                  o_busy;
    logic                  o_done;
    score_t                o_score;
    pe_idx_t               o_end_ref;
    qpos_t                 o_end_query;

    logic    check_idle;
    int      job_id;
    score_t  exp_score;
    pe_idx_t exp_ref;
    qpos_t   exp_query;
    int      n_tests;
    int      n_errors;

    base_t ref_b [NUM_PE];
    base_t qry   [MAX_QUERY_LEN];
    int    h_mat [NUM_PE][MAX_QUERY_LEN];
    int    e_mat [NUM_PE][MAX_QUERY_LEN];
    int    f_mat [NUM_PE][MAX_QUERY_LEN];
    int    lens  [NUM_RANDOM];
    int    cycles;
    int    cycle_limit;

    sw_align_top sw_align_top_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_ref         (i_ref),
        .i_query_valid (i_query_valid),
        .i_query_base  (i_query_base),
        .i_query_last  (i_query_last),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_score       (o_score),
        .o_end_ref     (o_end_ref),
        .o_end_query   (o_end_query)
    );

    sw_checker u_checker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_busy       (o_busy),
        .i_done       (o_done),
        .i_score      (o_score),
        .i_end_ref    (o_end_ref),
        .i_end_query  (o_end_query),
        .i_check_idle (check_idle),
        .i_job_id     (job_id),
        .i_exp_score  (exp_score),
        .i_exp_ref    (exp_ref),
        .i_exp_query  (exp_query),
        .o_tests      (n_tests),
        .o_errors     (n_errors)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles, o_done never arrived", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int max2(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // affine-gap local alignment, best cell by diagonal then row
    task automatic compute_model(input int len, output int best, output int br,
                                 output int bc);
        int hl;
        int el;
        int hu;
        int fu;
        int hd;
        int s;
        int j;
        best = 0;
        br   = 0;
        bc   = 0;
        for (int r = 0; r < NUM_PE; r++) begin
            for (int c = 0; c < len; c++) begin
                hl = (c > 0) ? h_mat[r][c-1] : 0;
                el = (c > 0) ? e_mat[r][c-1] : NEG_BIG;
                hu = (r > 0) ? h_mat[r-1][c] : 0;
                fu = (r > 0) ? f_mat[r-1][c] : NEG_BIG;
                hd = (r > 0 && c > 0) ? h_mat[r-1][c-1] : 0;
                s  = (ref_b[r] == qry[c]) ? MATCH_SCORE : MISMATCH_SCORE;
                e_mat[r][c] = max2(hl - GAP_OPEN, el - GAP_EXTEND);
                f_mat[r][c] = max2(hu - GAP_OPEN, fu - GAP_EXTEND);
                h_mat[r][c] = max2(max2(0, hd + s), max2(e_mat[r][c], f_mat[r][c]));
            end
        end
        for (int d = 0; d < NUM_PE + len - 1; d++) begin
            for (int r = 0; r < NUM_PE; r++) begin
                j = d - r;
                if (j >= 0 && j < len && h_mat[r][j] > best) begin
                    best = h_mat[r][j];
                    br   = r;
                    bc   = j;
                end
            end
        end
    endtask

    task automatic run_job(input int len);
        int best;
        int br;
        int bc;
        logic [2*NUM_PE-1:0] ref_vec;
        compute_model(len, best, br, bc);
        for (int i = 0; i < NUM_PE; i++) begin
            ref_vec[2*i +: 2] = ref_b[i];
        end
        @(posedge i_clk);
        i_start   <= 1'b1;
        i_ref     <= ref_vec;
        job_id    <= job_id + 1;
        exp_score <= score_t'(best);
        exp_ref   <= pe_idx_t'(br);
        exp_query <= qpos_t'(bc);
        for (int c = 0; c < len; c++) begin
            @(posedge i_clk);
            i_start       <= 1'b0;
            i_query_valid <= 1'b1;
            i_query_base  <= qry[c];
            i_query_last  <= (c == len - 1);
        end
        @(posedge i_clk);
        i_query_valid <= 1'b0;
        i_query_last  <= 1'b0;
        do begin
            @(posedge i_clk);
        end while (!o_done);
    endtask

    task automatic random_ref;
        for (int i = 0; i < NUM_PE; i++) begin
            ref_b[i] = base_t'($urandom_range(0, 3));
        end
    endtask

    initial begin
        int seed_val;
        int total;
        int k;
        seed_val = $urandom(32'h8465);
        i_clk         = 1'b0;
        i_rst         = 1'b1;
        i_start       = 1'b0;
        i_ref         = '0;
        i_query_valid = 1'b0;
        i_query_base  = '0;
        i_query_last  = 1'b0;
        check_idle    = 1'b0;
        job_id        = 0;
        exp_score     = '0;
        exp_ref       = '0;
        exp_query     = '0;
        cycles        = 0;
        total = 3 * NUM_PE + MAX_QUERY_LEN;
        for (int t = 0; t < NUM_RANDOM; t++) begin
            lens[t] = $urandom_range(1, 64);
            total   = total + lens[t];
        end
        cycle_limit = total + (NUM_TESTS - 1) * (NUM_PE + 4) + 100;

        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        check_idle <= 1'b1;
        @(posedge i_clk);
        check_idle <= 1'b0;

        // exact match
        random_ref();
        for (int c = 0; c < NUM_PE; c++) begin
            qry[c] = ref_b[c];
        end
        run_job(NUM_PE);

        // disjoint alphabets, nothing scores
        for (int i = 0; i < NUM_PE; i++) begin
            ref_b[i] = base_t'($urandom_range(0, 1));
            qry[i]   = base_t'($urandom_range(2, 3));
        end
        run_job(NUM_PE);

        // one inserted base after row 0, row 8 deleted
        // rows 1..7 and 9..15 are long enough that bridging the gap pays
        random_ref();
        k = 0;
        for (int r = 0; r < NUM_PE; r++) begin
            if (r != 8) begin
                qry[k] = ref_b[r];
                k = k + 1;
            end
            if (r == 0) begin
                qry[k] = ~ref_b[1];
                k = k + 1;
            end
        end
        run_job(k);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            random_ref();
            for (int c = 0; c < lens[t]; c++) begin
                qry[c] = base_t'($urandom_range(0, 3));
            end
            run_job(lens[t]);
        end

        // longest query, column counter near its top
        random_ref();
        for (int c = 0; c < MAX_QUERY_LEN; c++) begin
            qry[c] = base_t'($urandom_range(0, 3));
        end
        run_job(MAX_QUERY_LEN);

        repeat (2) @(posedge i_clk);
        $display("tests run %0d of %0d, errors %0d", n_tests, NUM_TESTS, n_errors);
        if (n_errors == 0 && n_tests == NUM_TESTS) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/sw_checker.sv
module sw_checker (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_start,
    input  logic            i_busy,
    input  logic            i_done,
    input  sw_pkg::score_t  i_score,
    input  sw_pkg::pe_idx_t i_end_ref,
    input  sw_pkg::qpos_t   i_end_query,
    input  logic            i_check_idle,
    input  int              i_job_id,
    input  sw_pkg::score_t  i_exp_score,
    input  sw_pkg::pe_idx_t i_exp_ref,
    input  sw_pkg::qpos_t   i_exp_query,
    output int              o_tests,
    output int              o_errors
);
    import sw_pkg::*;

    logic start_d;
    int   last_id;

    initial begin
        o_tests  = 0;
        o_errors = 0;
        last_id  = 0;
        start_d  = 1'b0;
    end

    // busy must follow an accepted start by one cycle
    always @(posedge i_clk) begin
        if (!i_rst && start_d && !i_busy) begin
            $display("Error at %0t: o_busy did not rise after i_start", $time);
            o_errors = o_errors + 1;
        end
        start_d = i_start && !i_busy && !i_rst;
    end

    always @(posedge i_clk) begin
        int bad;
        bad = 0;
        if (!i_rst && i_check_idle) begin
            if (i_busy || i_done) begin
                $display("Error at %0t: o_busy or o_done high after reset", $time);
                bad = bad + 1;
            end
            if (i_score != '0 || i_end_ref != '0 || i_end_query != '0) begin
                $display("Error at %0t: result outputs not zero after reset", $time);
                bad = bad + 1;
            end
            $display("test 0 (reset state): %s", (bad == 0) ? "ok" : "FAILED");
            o_tests  = o_tests + 1;
            o_errors = o_errors + bad;
        end
        if (!i_rst && i_done) begin
            if (i_job_id == last_id) begin
                $display("Error at %0t: o_done pulsed with no job running", $time);
                bad = bad + 1;
            end
            if (i_busy) begin
                $display("Error at %0t: o_busy still high with o_done", $time);
                bad = bad + 1;
            end
            if (i_score != i_exp_score) begin
                $display("Mismatch at %0t: o_score expected %0d got %0d",
                         $time, i_exp_score, i_score);
                bad = bad + 1;
            end
            if (i_end_ref != i_exp_ref) begin
                $display("Mismatch at %0t: o_end_ref expected %0d got %0d",
                         $time, i_exp_ref, i_end_ref);
                bad = bad + 1;
            end
            if (i_end_query != i_exp_query) begin
                $display("Mismatch at %0t: o_end_query expected %0d got %0d",
                         $time, i_exp_query, i_end_query);
                bad = bad + 1;
            end
            $display("test %0d: %s", i_job_id, (bad == 0) ? "ok" : "FAILED");
            last_id  = i_job_id;
            o_tests  = o_tests + 1;
            o_errors = o_errors + bad;
        end
    end

endmodule

// File: logic/sw_align_top.sv
module sw_align_top (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_start,
    input  logic [2*sw_pkg::NUM_PE-1:0] i_ref,
    input  logic                        i_query_valid,
    input  sw_pkg::base_t               i_query_base,
    input  logic                        i_query_last,
    output logic                        o_busy,
    output logic                        o_done,
    output sw_pkg::score_t              o_score,
    output sw_pkg::pe_idx_t             o_end_ref,
    output sw_pkg::qpos_t               o_end_query
);
    import sw_pkg::*;

    logic [NUM_PE-1:0] pe_valid;
    score_t            pe_h [NUM_PE];
    logic              any_valid;
    score_t            max_h;
    pe_idx_t           max_idx;

    sw_pe_array u_array (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_ref         (i_ref),
        .i_query_valid (i_query_valid),
        .i_query_base  (i_query_base),
        .o_valid       (pe_valid),
        .o_h           (pe_h)
    );

    score_max_tree u_tree (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (pe_valid),
        .i_h         (pe_h),
        .o_any_valid (any_valid),
        .o_max       (max_h),
        .o_idx       (max_idx)
    );

    sw_align_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_query_valid (i_query_valid),
        .i_query_last  (i_query_last),
        .i_any_valid   (any_valid),
        .i_max         (max_h),
        .i_idx         (max_idx),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_score       (o_score),
        .o_end_ref     (o_end_ref),
        .o_end_query   (o_end_query)
    );

endmodule

// File: logic/sw_align_ctrl.sv
module sw_align_ctrl (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_start,
    input  logic            i_query_valid,
    input  logic            i_query_last,
    input  logic            i_any_valid,
    input  sw_pkg::score_t  i_max,
    input  sw_pkg::pe_idx_t i_idx,
    output logic            o_busy,
    output logic            o_done,
    output sw_pkg::score_t  o_score,
    output sw_pkg::pe_idx_t o_end_ref,
    output sw_pkg::qpos_t   o_end_query
);
    import sw_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        DRAIN
    } state_t;

    typedef logic [PE_IDX_W:0] drain_t;

    state_t state;
    drain_t drain_cnt;
    // column seen by PE 0 for the current tree result
    qpos_t  wave;
    qpos_t  win_col;

    assign o_busy  = (state != IDLE);
    assign win_col = wave - qpos_t'(i_idx);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= IDLE;
            drain_cnt <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (i_query_valid && i_query_last) begin
                        state     <= DRAIN;
                        // last column still has to cross the array and the tree
                        drain_cnt <= drain_t'(NUM_PE);
                    end
                end
                DRAIN: begin
                    if (drain_cnt == '0) begin
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wave        <= '0;
            o_score     <= '0;
            o_end_ref   <= '0;
            o_end_query <= '0;
        end else if (i_start && !o_busy) begin
            wave        <= '0;
            o_score     <= '0;
            o_end_ref   <= '0;
            o_end_query <= '0;
        end else if (i_any_valid) begin
            wave <= wave + 1'b1;
            // earlier diagonal keeps the title on a tie
            if (i_max > o_score) begin
                o_score     <= i_max;
                o_end_ref   <= i_idx;
                o_end_query <= win_col;
            end
        end
    end

    a_start_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> !o_busy)
        else $error("start while busy");

    a_query_in_job: assert property (@(posedge i_clk) disable iff (i_rst)
        i_query_valid |-> (state != IDLE))
        else $error("query base outside a job");

    // done lands a fixed distance after the final base
    a_done_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |-> $past(i_query_valid && i_query_last, NUM_PE + 2))
        else $error("done at wrong cycle");

endmodule

// File: logic/score_max_tree.sv
module score_max_tree (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [sw_pkg::NUM_PE-1:0] i_valid,
    input  sw_pkg::score_t            i_h [sw_pkg::NUM_PE],
    output logic                      o_any_valid,
    output sw_pkg::score_t            o_max,
    output sw_pkg::pe_idx_t           o_idx
);
    import sw_pkg::*;

    // level 0 holds the lanes, level PE_IDX_W the winner
    score_t  lvl_h   [PE_IDX_W+1][NUM_PE];
    pe_idx_t lvl_idx [PE_IDX_W+1][NUM_PE];

    always_comb begin
        for (int l = 0; l <= PE_IDX_W; l++) begin
            for (int i = 0; i < NUM_PE; i++) begin
                lvl_h[l][i]   = NEG_INF;
                lvl_idx[l][i] = '0;
            end
        end

        // idle lanes never win
        for (int i = 0; i < NUM_PE; i++) begin
            lvl_h[0][i]   = i_valid[i] ? i_h[i] : NEG_INF;
            lvl_idx[0][i] = pe_idx_t'(i);
        end

        // pairwise compare, lower index kept on a tie
        for (int l = 0; l < PE_IDX_W; l++) begin
            for (int i = 0; i < (NUM_PE >> (l + 1)); i++) begin
                if (lvl_h[l][2*i] >= lvl_h[l][2*i+1]) begin
                    lvl_h[l+1][i]   = lvl_h[l][2*i];
                    lvl_idx[l+1][i] = lvl_idx[l][2*i];
                end else begin
                    lvl_h[l+1][i]   = lvl_h[l][2*i+1];
                    lvl_idx[l+1][i] = lvl_idx[l][2*i+1];
                end
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_any_valid <= 1'b0;
        end else begin
            o_any_valid <= |i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_max <= lvl_h[PE_IDX_W][0];
        o_idx <= lvl_idx[PE_IDX_W][0];
    end

endmodule

// File: logic/sw_pe_array.sv
module sw_pe_array (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_start,
    input  logic [2*sw_pkg::NUM_PE-1:0]   i_ref,
    input  logic                          i_query_valid,
    input  sw_pkg::base_t                 i_query_base,
    output logic [sw_pkg::NUM_PE-1:0]     o_valid,
    output sw_pkg::score_t                o_h [sw_pkg::NUM_PE]
);
    import sw_pkg::*;

    // link k feeds PE k, link NUM_PE leaves the last PE
    pe_link_if link [NUM_PE+1] ();

    // top boundary row of the local alignment
    assign link[0].valid = i_query_valid;
    assign link[0].base  = i_query_base;
    assign link[0].h     = '0;
    assign link[0].f     = NEG_INF;

    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        // start reloads the reference base and clears the row
        sw_pe u_pe (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_clear    (i_start),
            .i_ref_base (i_ref[2*k +: 2]),
            .up         (link[k]),
            .down       (link[k+1]),
            .o_valid    (o_valid[k]),
            .o_h        (o_h[k])
        );
    end

endmodule

// File: logic/sw_pe.sv
module sw_pe (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_clear,
    input  sw_pkg::base_t  i_ref_base,
    pe_link_if.sink        up,
    pe_link_if.source      down,
    output logic           o_valid,
    output sw_pkg::score_t o_h
);
    import sw_pkg::*;

    base_t  ref_base;
    // row state: left neighbour and diagonal
    score_t h_left;
    score_t e_left;
    score_t h_diag;

    score_t e_open;
    score_t e_ext;
    score_t e_new;
    score_t f_open;
    score_t f_ext;
    score_t f_new;
    score_t s_diag;
    score_t h_new;

    function automatic score_t sat_add(score_t a, int d);
        int sum;
        sum = int'(a) + d;
        if (sum < int'(NEG_INF)) begin
            return NEG_INF;
        end
        return score_t'(sum);
    endfunction

    always_comb begin
        e_open = sat_add(h_left, -GAP_OPEN);
        e_ext  = sat_add(e_left, -GAP_EXTEND);
        e_new  = (e_open > e_ext) ? e_open : e_ext;

        f_open = sat_add(up.h, -GAP_OPEN);
        f_ext  = sat_add(up.f, -GAP_EXTEND);
        f_new  = (f_open > f_ext) ? f_open : f_ext;

        s_diag = sat_add(h_diag, (up.base == ref_base) ? MATCH_SCORE : MISMATCH_SCORE);

        // local alignment floor
        h_new = '0;
        if (s_diag > h_new) begin
            h_new = s_diag;
        end
        if (e_new > h_new) begin
            h_new = e_new;
        end
        if (f_new > h_new) begin
            h_new = f_new;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            ref_base <= i_ref_base;
            h_left   <= '0;
            e_left   <= NEG_INF;
            h_diag   <= '0;
        end else if (up.valid) begin
            h_left <= h_new;
            e_left <= e_new;
            h_diag <= up.h;
        end
        if (up.valid) begin
            down.base <= up.base;
            down.h    <= h_new;
            down.f    <= f_new;
        end
    end

    assign o_valid = down.valid;
    assign o_h     = down.h;

    // every accepted column leaves with a non-negative score
    a_h_nonneg: assert property (@(posedge i_clk) disable iff (i_rst)
        up.valid |=> !o_h[SCORE_W-1])
        else $error("PE score negative");

endmodule

// File: logic/pe_link_if.sv
interface pe_link_if;
    import sw_pkg::*;

    // one query column moving down the chain
    logic   valid;
    base_t  base;
    score_t h;
    // gap score along the reference, from the row above
    score_t f;

    modport source (
        output valid,
        output base,
        output h,
        output f
    );

    modport sink (
        input valid,
        input base,
        input h,
        input f
    );

endinterface

// File: logic/sw_pkg.sv
package sw_pkg;

    // array geometry
    localparam int NUM_PE        = 16;
    localparam int PE_IDX_W      = $clog2(NUM_PE);

    // datapath widths
    localparam int SCORE_W       = 14;
    localparam int QPOS_W        = 10;
    localparam int MAX_QUERY_LEN = 1000;

    // affine gap scoring
    localparam int MATCH_SCORE    = 2;
    localparam int MISMATCH_SCORE = -3;
    localparam int GAP_OPEN       = 12;
    localparam int GAP_EXTEND     = 1;

    // nucleotide code, A/C/G/T in two bits
    typedef logic [1:0]                base_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [QPOS_W-1:0]         qpos_t;
    typedef logic [PE_IDX_W-1:0]       pe_idx_t;

    // most negative score, stands in for minus infinity
    localparam score_t NEG_INF = {1'b1, {(SCORE_W-1){1'b0}}};

endpackage
